//--- Bender.yml
package:
  name: csr_file

sources:
  - hw/csr_pkg.sv
  - hw/csr_write_ctrl.sv
  - hw/csr_machine_regs.sv
  - hw/csr_counters.sv
  - hw/csr_read_mux.sv
  - hw/csr_file_top.sv
  - target: simulation
    files:
      - sim/tb_csr_file.sv

//--- csr_file.f
hw/csr_pkg.sv
hw/csr_write_ctrl.sv
hw/csr_machine_regs.sv
hw/csr_counters.sv
hw/csr_read_mux.sv
hw/csr_file_top.sv
sim/tb_csr_file.sv

//--- hw/csr_counters.sv
/*
 * Machine cycle and instret counters
 * 64-bit mcycle / minstret with split 32-bit writes and mcountinhibit
 */
`timescale 1ns/1ps

module csr_counters import csr_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  csr_wr_t              wr_i,
  input  logic                 retire_i,
  output logic [CNT_WIDTH-1:0] mcycle_o,
  output logic [CNT_WIDTH-1:0] minstret_o,
  output logic [XLEN-1:0]      mcountinhibit_o
);

  logic [CNT_WIDTH-1:0] mcycle_q, minstret_q;
  logic                 cy_inhibit_q, ir_inhibit_q;   // mcountinhibit bits 0 and 2
  logic                 wr_cy_lo, wr_cy_hi;
  logic                 wr_ir_lo, wr_ir_hi;
  logic                 wr_inhibit;
  logic                 cy_inc, ir_inc;

  // Half write replaces that half, otherwise step by one
  function automatic logic [CNT_WIDTH-1:0] cnt_next(
    input logic [CNT_WIDTH-1:0] cnt,
    input logic                 wr_lo,
    input logic                 wr_hi,
    input logic                 inc,
    input logic [XLEN-1:0]      data
  );
    logic [CNT_WIDTH-1:0] nxt;
    nxt = cnt;
    if (wr_lo) begin
      nxt[XLEN-1:0] = data;
    end else if (wr_hi) begin
      nxt[CNT_WIDTH-1:XLEN] = data;
    end else if (inc) begin
      nxt = cnt + CNT_WIDTH'(1);
    end
    return nxt;
  endfunction

  //////////////////////////////
  // Write decode
  //////////////////////////////
  assign wr_cy_lo   = wr_i.we && (wr_i.addr == CSR_MCYCLE);
  assign wr_cy_hi   = wr_i.we && (wr_i.addr == CSR_MCYCLEH);
  assign wr_ir_lo   = wr_i.we && (wr_i.addr == CSR_MINSTRET);
  assign wr_ir_hi   = wr_i.we && (wr_i.addr == CSR_MINSTRETH);
  assign wr_inhibit = wr_i.we && (wr_i.addr == CSR_MCOUNTINHIBIT);

  // Software write wins over the increment
  assign cy_inc = !cy_inhibit_q;
  assign ir_inc = !ir_inhibit_q && retire_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mcycle_q     <= '0;
      minstret_q   <= '0;
      cy_inhibit_q <= CNT_INHIBIT_RESET[0];
      ir_inhibit_q <= CNT_INHIBIT_RESET[2];
    end else begin
      mcycle_q   <= cnt_next(mcycle_q, wr_cy_lo, wr_cy_hi, cy_inc, wr_i.data);
      minstret_q <= cnt_next(minstret_q, wr_ir_lo, wr_ir_hi, ir_inc, wr_i.data);
      if (wr_inhibit) begin
        cy_inhibit_q <= wr_i.data[0];
        ir_inhibit_q <= wr_i.data[2];
      end
    end
  end

  assign mcycle_o        = mcycle_q;
  assign minstret_o      = minstret_q;
  assign mcountinhibit_o = {29'b0, ir_inhibit_q, 1'b0, cy_inhibit_q};  // TM bit reads 0

  // One WB write per cycle, so never both halves of a counter
  cnt_split_wr_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_cy_lo && wr_cy_hi) && !(wr_ir_lo && wr_ir_hi))
    else $error("Low and high counter half written together");

endmodule

//--- hw/csr_file_top.sv
/*
 * Machine-mode CSR file
 * Read in EX, read-modify-write in WB, trap and MRET updates from the
 * controller, mcycle / minstret counters
 */
`timescale 1ns/1ps

module csr_file_top import csr_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // System
  input  logic [XLEN-1:0]   hart_id_i,
  input  logic [XLEN-1:0]   mip_i,
  input  logic              mtvec_init_i,
  input  logic [XLEN-1:0]   mtvec_boot_addr_i,
  // Controller
  input  csr_rd_req_t       rd_req_i,       // EX stage
  input  csr_wb_req_t       wb_req_i,       // WB stage
  input  trap_ctrl_t        trap_i,
  input  logic              retire_i,
  // Read port
  output logic [XLEN-1:0]   rd_data_o,
  output logic              illegal_o,
  // Direct register outputs
  output logic [XLEN-1:0]   mie_o,
  output logic [XLEN-1:0]   mepc_o,
  output logic [23:0]       mtvec_addr_o,
  output logic [1:0]        mtvec_mode_o,
  output logic              m_irq_enable_o
);

  csr_wr_t              wr;             // Resolved WB write
  mstatus_t             mstatus;
  mtvec_t               mtvec;
  mcause_t              mcause;
  logic [XLEN-1:0]      mie;
  logic [XLEN-1:0]      mscratch;
  logic [XLEN-1:0]      mepc;
  logic [CNT_WIDTH-1:0] mcycle;
  logic [CNT_WIDTH-1:0] minstret;
  logic [XLEN-1:0]      mcountinhibit;

  csr_write_ctrl u_write_ctrl (
    .wb_req_i (wb_req_i),
    .wr_o     (wr)
  );

  csr_machine_regs u_machine_regs (
    .clk               (clk),
    .rst_n             (rst_n),
    .wr_i              (wr),
    .trap_i            (trap_i),
    .mtvec_init_i      (mtvec_init_i),
    .mtvec_boot_addr_i (mtvec_boot_addr_i),
    .mstatus_o         (mstatus),
    .mie_o             (mie),
    .mtvec_o           (mtvec),
    .mscratch_o        (mscratch),
    .mepc_o            (mepc),
    .mcause_o          (mcause),
    .m_irq_enable_o    (m_irq_enable_o)
  );

  csr_counters u_counters (
    .clk             (clk),
    .rst_n           (rst_n),
    .wr_i            (wr),
    .retire_i        (retire_i),
    .mcycle_o        (mcycle),
    .minstret_o      (minstret),
    .mcountinhibit_o (mcountinhibit)
  );

  csr_read_mux u_read_mux (
    .rd_req_i        (rd_req_i),
    .hart_id_i       (hart_id_i),
    .mip_i           (mip_i),
    .mstatus_i       (mstatus),
    .mie_i           (mie),
    .mtvec_i         (mtvec),
    .mscratch_i      (mscratch),
    .mepc_i          (mepc),
    .mcause_i        (mcause),
    .mcycle_i        (mcycle),
    .minstret_i      (minstret),
    .mcountinhibit_i (mcountinhibit),
    .rd_data_o       (rd_data_o),
    .illegal_o       (illegal_o)
  );

  assign mie_o        = mie;
  assign mepc_o       = mepc;
  assign mtvec_addr_o = mtvec.addr;   // To fetch, trap target
  assign mtvec_mode_o = mtvec.mode;

endmodule

//--- hw/csr_machine_regs.sv
/*
 * Machine trap setup and handling registers
 * mstatus, mie, mtvec, mscratch, mepc and mcause with software writes,
 * trap entry, MRET restore and boot address load of mtvec
 */
`timescale 1ns/1ps

module csr_machine_regs import csr_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  csr_wr_t         wr_i,
  input  trap_ctrl_t      trap_i,
  input  logic            mtvec_init_i,
  input  logic [XLEN-1:0] mtvec_boot_addr_i,
  output mstatus_t        mstatus_o,
  output logic [XLEN-1:0] mie_o,
  output mtvec_t          mtvec_o,
  output logic [XLEN-1:0] mscratch_o,
  output logic [XLEN-1:0] mepc_o,
  output mcause_t         mcause_o,
  output logic            m_irq_enable_o
);

  mstatus_t        mstatus_q, mstatus_n;
  mtvec_t          mtvec_q, mtvec_n;
  mcause_t         mcause_q, mcause_n;
  logic [XLEN-1:0] mie_q, mscratch_q, mepc_q;
  logic [XLEN-1:0] mepc_n;
  logic            mstatus_we, mtvec_we, mcause_we, mepc_we;
  logic            mie_we, mscratch_we;
  mstatus_t        wr_status;        // Write data, register views
  mtvec_t          wr_tvec;
  mcause_t         wr_cause;

  assign wr_status = mstatus_t'(wr_i.data);
  assign wr_tvec   = mtvec_t'(wr_i.data);
  assign wr_cause  = mcause_t'(wr_i.data);

  // Software write decode
  assign mie_we      = wr_i.we && (wr_i.addr == CSR_MIE);
  assign mscratch_we = wr_i.we && (wr_i.addr == CSR_MSCRATCH);

  //////////////////////////////
  // Next state
  //////////////////////////////
  always_comb begin
    // Software writes first, WARL fields fixed up here
    mstatus_n  = '{mpp: PRIV_M, mpie: wr_status.mpie, mie: wr_status.mie, default: '0};
    mstatus_we = wr_i.we && (wr_i.addr == CSR_MSTATUS);
    mepc_n     = {wr_i.data[XLEN-1:1], 1'b0};     // No odd PCs
    mepc_we    = wr_i.we && (wr_i.addr == CSR_MEPC);
    mcause_n   = '{irq: wr_cause.irq, exccode: wr_cause.exccode, default: '0};
    mcause_we  = wr_i.we && (wr_i.addr == CSR_MCAUSE);
    mtvec_n    = '{addr: wr_tvec.addr, mode: {1'b0, wr_tvec.mode[0]}, default: '0};
    mtvec_we   = wr_i.we && (wr_i.addr == CSR_MTVEC);

    // Controller overrides software
    if (trap_i.save_cause && !trap_i.restore_mret) begin
      mstatus_n      = mstatus_q;
      mstatus_n.mpie = mstatus_q.mie;             // Stack IE
      mstatus_n.mie  = 1'b0;
      mstatus_n.mpp  = PRIV_M;
      mstatus_we     = 1'b1;
      mepc_n         = trap_i.pc;
      mepc_we        = 1'b1;
      mcause_n       = '{irq: trap_i.cause[6], exccode: trap_i.cause[5:0], default: '0};
      mcause_we      = 1'b1;
    end else if (trap_i.restore_mret) begin
      mstatus_n      = mstatus_q;
      mstatus_n.mie  = mstatus_q.mpie;            // Pop IE
      mstatus_n.mpie = 1'b1;
      mstatus_n.mpp  = PRIV_M;
      mstatus_we     = 1'b1;
    end

    // Boot address load keeps the mode
    if (mtvec_init_i) begin
      mtvec_n.addr = mtvec_boot_addr_i[XLEN-1:8];
      mtvec_n.mode = mtvec_q.mode;
      mtvec_we     = 1'b1;
    end
  end

  //////////////////////////////
  // Registers
  //////////////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mstatus_q  <= MSTATUS_RESET_VAL;
      mtvec_q    <= MTVEC_RESET_VAL;
      mcause_q   <= '0;
      mie_q      <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
    end else begin
      if (mstatus_we)  mstatus_q  <= mstatus_n;
      if (mtvec_we)    mtvec_q    <= mtvec_n;
      if (mcause_we)   mcause_q   <= mcause_n;
      if (mie_we)      mie_q      <= wr_i.data & IRQ_MASK;  // Unimplemented IRQs stay 0
      if (mscratch_we) mscratch_q <= wr_i.data;
      if (mepc_we)     mepc_q     <= mepc_n;
    end
  end

  assign mstatus_o      = mstatus_q;
  assign mie_o          = mie_q;
  assign mtvec_o        = mtvec_q;
  assign mscratch_o     = mscratch_q;
  assign mepc_o         = mepc_q;
  assign mcause_o       = mcause_q;
  assign m_irq_enable_o = mstatus_q.mie;   // Global M-mode IE

  // Controller FSM issues trap entry and MRET in separate cycles
  trap_mret_excl_a: assert property (@(posedge clk) disable iff (!rst_n)
    !(trap_i.save_cause && trap_i.restore_mret))
    else $error("Trap save and MRET restore in the same cycle");

endmodule

//--- hw/csr_pkg.sv
/*
 * Machine-mode CSR file package
 * CSR addresses, access opcodes, register layouts, port structs and
 * the architectural constants shared by every block of the CSR file
 */
package csr_pkg;

  //////////////////////////////
  // Widths and constants
  //////////////////////////////
  localparam int unsigned XLEN      = 32;
  localparam int unsigned CNT_WIDTH = 64;  // mcycle / minstret

  localparam logic [1:0] PRIV_M = 2'b11;   // Only machine mode exists

  // MSIE, MTIE, MEIE plus fast interrupts 16..31
  localparam logic [XLEN-1:0] IRQ_MASK = 32'hFFFF_0888;

  localparam logic [XLEN-1:0] MISA_VALUE =
      (32'(1) <<  2)    // C
    | (32'(1) <<  8)    // I
    | (32'(1) << 12)    // M
    | (32'(1) << 30);   // MXL = 1, 32-bit

  // Both counters stopped out of reset
  localparam logic [XLEN-1:0] CNT_INHIBIT_RESET = 32'h0000_0005;

  //////////////////////////////
  // Enums
  //////////////////////////////
  typedef enum logic [11:0] {
    CSR_MSTATUS       = 12'h300,
    CSR_MISA          = 12'h301,
    CSR_MIE           = 12'h304,
    CSR_MTVEC         = 12'h305,
    CSR_MCOUNTINHIBIT = 12'h320,
    CSR_MSCRATCH      = 12'h340,
    CSR_MEPC          = 12'h341,
    CSR_MCAUSE        = 12'h342,
    CSR_MIP           = 12'h344,
    CSR_MCYCLE        = 12'hB00,
    CSR_MINSTRET      = 12'hB02,
    CSR_MCYCLEH       = 12'hB80,
    CSR_MINSTRETH     = 12'hB82,
    CSR_MHARTID       = 12'hF14   // Read-only range
  } csr_num_e;

  typedef enum logic [1:0] {
    CSR_OP_READ  = 2'b00,
    CSR_OP_WRITE = 2'b01,
    CSR_OP_SET   = 2'b10,
    CSR_OP_CLEAR = 2'b11
  } csr_op_e;

  //////////////////////////////
  // Register layouts
  //////////////////////////////
  typedef struct packed {
    logic [18:0] zero3;   // 31:13
    logic [1:0]  mpp;     // 12:11
    logic [2:0]  zero2;   // 10:8
    logic        mpie;    // 7
    logic [2:0]  zero1;   // 6:4
    logic        mie;     // 3
    logic [2:0]  zero0;   // 2:0
  } mstatus_t;

  typedef struct packed {
    logic [23:0] addr;    // Base, 256 byte aligned
    logic [5:0]  zero0;
    logic [1:0]  mode;    // 0 direct, 1 vectored
  } mtvec_t;

  typedef struct packed {
    logic        irq;     // Interrupt flag
    logic [24:0] zero0;
    logic [5:0]  exccode;
  } mcause_t;

  localparam mstatus_t MSTATUS_RESET_VAL = '{mpp: PRIV_M, default: '0};
  localparam mtvec_t   MTVEC_RESET_VAL   = '{mode: 2'b01, default: '0};

  //////////////////////////////
  // Port structs
  //////////////////////////////
  typedef struct packed {
    logic        valid;
    csr_op_e     op;
    logic [11:0] addr;    // Raw, may be unknown CSR
  } csr_rd_req_t;

  typedef struct packed {
    logic            valid;
    logic            kill;       // Flushed in WB
    csr_op_e         op;
    logic [11:0]     addr;
    logic [XLEN-1:0] operand;    // rs1 or immediate
    logic [XLEN-1:0] old_value;  // Value read in EX
  } csr_wb_req_t;

  typedef struct packed {
    logic            we;
    logic [11:0]     addr;
    logic [XLEN-1:0] data;
  } csr_wr_t;

  typedef struct packed {
    logic            save_cause;
    logic            restore_mret;
    logic [6:0]      cause;      // {irq, code}
    logic [XLEN-1:0] pc;
  } trap_ctrl_t;

endpackage

//--- hw/csr_read_mux.sv
/*
 * CSR read multiplexer
 * Decodes the EX read address, returns the CSR value and flags
 * unknown CSRs and writes to the read-only range
 */
`timescale 1ns/1ps

module csr_read_mux import csr_pkg::*; (
  input  csr_rd_req_t          rd_req_i,
  input  logic [XLEN-1:0]      hart_id_i,
  input  logic [XLEN-1:0]      mip_i,
  input  mstatus_t             mstatus_i,
  input  logic [XLEN-1:0]      mie_i,
  input  mtvec_t               mtvec_i,
  input  logic [XLEN-1:0]      mscratch_i,
  input  logic [XLEN-1:0]      mepc_i,
  input  mcause_t              mcause_i,
  input  logic [CNT_WIDTH-1:0] mcycle_i,
  input  logic [CNT_WIDTH-1:0] minstret_i,
  input  logic [XLEN-1:0]      mcountinhibit_i,
  output logic [XLEN-1:0]      rd_data_o,
  output logic                 illegal_o
);

  logic [XLEN-1:0] rd_data;
  logic            illegal_rd;   // No such CSR
  logic            illegal_wr;   // Write to read-only range

  //////////////////////////////
  // Read select
  //////////////////////////////
  always_comb begin
    illegal_rd = 1'b0;
    case (rd_req_i.addr)
      CSR_MSTATUS:       rd_data = mstatus_i;
      CSR_MISA:          rd_data = MISA_VALUE;          // Fixed ISA
      CSR_MIE:           rd_data = mie_i;
      CSR_MTVEC:         rd_data = mtvec_i;
      CSR_MSCRATCH:      rd_data = mscratch_i;
      CSR_MEPC:          rd_data = mepc_i;
      CSR_MCAUSE:        rd_data = mcause_i;
      CSR_MIP:           rd_data = mip_i & IRQ_MASK;    // Live pending lines
      CSR_MCOUNTINHIBIT: rd_data = mcountinhibit_i;
      CSR_MCYCLE:        rd_data = mcycle_i[XLEN-1:0];
      CSR_MCYCLEH:       rd_data = mcycle_i[CNT_WIDTH-1:XLEN];
      CSR_MINSTRET:      rd_data = minstret_i[XLEN-1:0];
      CSR_MINSTRETH:     rd_data = minstret_i[CNT_WIDTH-1:XLEN];
      CSR_MHARTID:       rd_data = hart_id_i;
      default: begin
        // Unimplemented CSR
        rd_data    = '0;
        illegal_rd = 1'b1;
      end
    endcase
  end

  // Addresses 0xC00..0xFFF are read-only by encoding
  assign illegal_wr = (rd_req_i.op != CSR_OP_READ) && (rd_req_i.addr[11:10] == 2'b11);

  assign rd_data_o = rd_data;
  assign illegal_o = rd_req_i.valid && (illegal_rd || illegal_wr);  // Quiet when idle

endmodule

//--- hw/csr_write_ctrl.sv
/*
 * CSR write control
 * Qualifies the WB request and builds the write data from the EX read value
 */
`timescale 1ns/1ps

module csr_write_ctrl import csr_pkg::*; (
  input  csr_wb_req_t wb_req_i,
  output csr_wr_t     wr_o
);

  logic wr_active;

  // Killed or bubble in WB never writes
  assign wr_active = wb_req_i.valid && !wb_req_i.kill;

  always_comb begin
    wr_o.addr = wb_req_i.addr;
    wr_o.we   = wr_active;
    case (wb_req_i.op)
      CSR_OP_WRITE: wr_o.data = wb_req_i.operand;
      CSR_OP_SET:   wr_o.data = wb_req_i.old_value | wb_req_i.operand;
      CSR_OP_CLEAR: wr_o.data = wb_req_i.old_value & ~wb_req_i.operand;
      default: begin                   // Plain read, csrrs/c with x0
        wr_o.data = wb_req_i.operand;
        wr_o.we   = 1'b0;
      end
    endcase

    // Controller must present a defined op with every valid WB slot
    op_known_a: assert final ((wb_req_i.valid !== 1'b1) || !$isunknown(wb_req_i.op))
      else $error("CSR WB op unknown while valid");
  end

endmodule

//--- sim/tb_csr_file.sv
/*
 * Testbench for the machine-mode CSR file
 * Table driven, with a reference model of the CSR rules
 */
`timescale 1ns/1ps

module tb_csr_file import csr_pkg::*; ();

  typedef enum {R_READ, R_NOREAD, R_WB, R_KILL, R_TRAP, R_MRET, R_IDLE, R_RETIRE,
                R_INIT} row_kind_e;

  typedef struct {
    row_kind_e       kind;
    csr_op_e         op;
    logic [11:0]     addr;
    logic [XLEN-1:0] data;     // Operand or boot address
    logic [XLEN-1:0] aux;      // Trap PC or cycle count
    logic [6:0]      cause;
    logic            exp_ill;  // Expected illegal_o on reads
  } row_t;

  logic clk, rst_n, mtvec_init, retire;
  logic [XLEN-1:0] hart_id, mip, boot_addr, rd_data, mie_out, mepc_out;
  logic [23:0] tvec_addr;
  logic [1:0]  tvec_mode;
  logic        illegal, irq_en;
  csr_rd_req_t rd_req;
  csr_wb_req_t wb_req;
  trap_ctrl_t  trap;
  row_t        rows[$];
  logic [31:0] rng;
  longint      timeout_ns = 0;

  // Reference model state
  logic m_st_mie, m_st_mpie;
  logic [XLEN-1:0] m_ie, m_scratch, m_epc, m_cause, m_inh;
  mtvec_t m_tvec;
  logic [CNT_WIDTH-1:0] m_cycle, m_instret;

  csr_file_top dut0 (
    .clk (clk), .rst_n (rst_n), .hart_id_i (hart_id), .mip_i (mip),
    .mtvec_init_i (mtvec_init), .mtvec_boot_addr_i (boot_addr),
    .rd_req_i (rd_req), .wb_req_i (wb_req), .trap_i (trap), .retire_i (retire),
    .rd_data_o (rd_data), .illegal_o (illegal), .mie_o (mie_out), .mepc_o (mepc_out),
    .mtvec_addr_o (tvec_addr), .mtvec_mode_o (tvec_mode), .m_irq_enable_o (irq_en)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;   // 100 MHz
  end

  //////////////////////////////
  // Helpers and checks
  //////////////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] rand_word();
    rng = xorshift32(rng);
    return rng;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_data(input string name, input logic [XLEN-1:0] got, exp);
    if (got !== exp)
      report_failure($sformatf("Error: %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    if (got !== exp)
      report_failure($sformatf("Error: %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic check_mtvec(input mtvec_t exp);
    check_data("mtvec_addr_o", {8'h0, tvec_addr}, {8'h0, exp.addr});
    check_data("mtvec_mode_o", {30'h0, tvec_mode}, {30'h0, exp.mode});
  endtask

  task automatic check_irq_mepc(input logic exp_en, input logic [XLEN-1:0] exp_mie,
                                input logic [XLEN-1:0] exp_mepc);
    check_flag("m_irq_enable_o", irq_en, exp_en);
    check_data("mie_o", mie_out, exp_mie);
    check_data("mepc_o", mepc_out, exp_mepc);
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////
  function automatic logic [XLEN-1:0] model_read(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS:       return {19'h0, PRIV_M, 3'h0, m_st_mpie, 3'h0, m_st_mie, 3'h0};
      CSR_MISA:          return MISA_VALUE;
      CSR_MIE:           return m_ie;
      CSR_MTVEC:         return m_tvec;
      CSR_MSCRATCH:      return m_scratch;
      CSR_MEPC:          return m_epc;
      CSR_MCAUSE:        return m_cause;
      CSR_MIP:           return mip & IRQ_MASK;
      CSR_MCOUNTINHIBIT: return m_inh;
      CSR_MCYCLE:        return m_cycle[31:0];
      CSR_MCYCLEH:       return m_cycle[63:32];
      CSR_MINSTRET:      return m_instret[31:0];
      CSR_MINSTRETH:     return m_instret[63:32];
      CSR_MHARTID:       return hart_id;
      default:           return '0;   // Unknown CSR
    endcase
  endfunction

  // One clock edge worth of state change, from the inputs driven
  function automatic void model_update();
    logic [XLEN-1:0] data;
    logic            we, save, old_mie;
    we = wb_req.valid && !wb_req.kill && (wb_req.op != CSR_OP_READ);
    case (wb_req.op)
      CSR_OP_SET:   data = wb_req.old_value | wb_req.operand;
      CSR_OP_CLEAR: data = wb_req.old_value & ~wb_req.operand;
      default:      data = wb_req.operand;
    endcase
    save    = trap.save_cause && !trap.restore_mret;
    old_mie = m_st_mie;
    if (save) begin
      m_st_mpie = old_mie;     // Stack IE
      m_st_mie  = 1'b0;
    end else if (trap.restore_mret) begin
      m_st_mie  = m_st_mpie;
      m_st_mpie = 1'b1;
    end else if (we && wb_req.addr == CSR_MSTATUS) begin
      m_st_mie  = data[3];
      m_st_mpie = data[7];
    end
    if (save) m_epc = trap.pc;
    else if (we && wb_req.addr == CSR_MEPC) m_epc = {data[31:1], 1'b0};
    if (save) m_cause = {trap.cause[6], 25'h0, trap.cause[5:0]};
    else if (we && wb_req.addr == CSR_MCAUSE) m_cause = {data[31], 25'h0, data[5:0]};
    if (we && wb_req.addr == CSR_MIE) m_ie = data & IRQ_MASK;
    if (we && wb_req.addr == CSR_MSCRATCH) m_scratch = data;
    if (mtvec_init) m_tvec.addr = boot_addr[31:8];   // Mode kept
    else if (we && wb_req.addr == CSR_MTVEC)
      m_tvec = '{addr: data[31:8], zero0: '0, mode: {1'b0, data[0]}};
    // Old inhibit bits gate this step
    if (we && wb_req.addr == CSR_MCYCLE) m_cycle[31:0] = data;
    else if (we && wb_req.addr == CSR_MCYCLEH) m_cycle[63:32] = data;
    else if (!m_inh[0]) m_cycle = m_cycle + 1;
    if (we && wb_req.addr == CSR_MINSTRET) m_instret[31:0] = data;
    else if (we && wb_req.addr == CSR_MINSTRETH) m_instret[63:32] = data;
    else if (!m_inh[2] && retire) m_instret = m_instret + 1;
    if (we && wb_req.addr == CSR_MCOUNTINHIBIT) m_inh = data & 32'h5;
  endfunction

  //////////////////////////////
  // Stimulus table
  //////////////////////////////
  task automatic add_row(input row_kind_e kind, input csr_op_e op, input logic [11:0] addr,
                         input logic [31:0] data, aux, input logic [6:0] cause,
                         input logic exp_ill);
    rows.push_back('{kind, op, addr, data, aux, cause, exp_ill});
  endtask

  task automatic add_read(input logic [11:0] addr);
    add_row(R_READ, CSR_OP_READ, addr, '0, '0, '0, 1'b0);
  endtask

  task automatic add_wb(input csr_op_e op, input logic [11:0] addr, input logic [31:0] d);
    add_row(R_WB, op, addr, d, '0, '0, 1'b0);
  endtask

  task automatic build_table();
    // Reset values
    add_read(CSR_MSTATUS);
    add_read(CSR_MISA);
    add_read(CSR_MHARTID);
    add_read(CSR_MTVEC);
    add_read(CSR_MCOUNTINHIBIT);
    add_read(CSR_MCYCLE);
    add_row(R_IDLE, CSR_OP_READ, '0, '0, 5, '0, 1'b0);
    add_read(CSR_MCYCLE);
    add_read(CSR_MIP);
    // Read-modify-write
    add_wb(CSR_OP_WRITE, CSR_MSCRATCH, rand_word());
    add_read(CSR_MSCRATCH);
    add_wb(CSR_OP_SET, CSR_MSCRATCH, rand_word());
    add_read(CSR_MSCRATCH);
    add_wb(CSR_OP_CLEAR, CSR_MSCRATCH, rand_word());
    add_read(CSR_MSCRATCH);
    add_wb(CSR_OP_WRITE, CSR_MIE, rand_word());
    add_read(CSR_MIE);
    add_wb(CSR_OP_WRITE, CSR_MEPC, rand_word() | 1);
    add_read(CSR_MEPC);
    add_row(R_KILL, CSR_OP_WRITE, CSR_MSCRATCH, rand_word(), '0, '0, 1'b0);
    add_read(CSR_MSCRATCH);
    add_wb(CSR_OP_READ, CSR_MSCRATCH, rand_word());
    add_read(CSR_MSCRATCH);
    // Illegal accesses
    add_row(R_READ, CSR_OP_READ, 12'h7C0, '0, '0, '0, 1'b1);
    add_row(R_READ, CSR_OP_WRITE, CSR_MHARTID, '0, '0, '0, 1'b1);
    add_row(R_READ, CSR_OP_WRITE, CSR_MISA, '0, '0, '0, 1'b0);  // Below the read-only range
    add_row(R_NOREAD, CSR_OP_WRITE, 12'hC55, '0, '0, '0, 1'b0);
    // Trap entry beats a same-cycle mepc write
    add_wb(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0008);
    add_read(CSR_MSTATUS);
    add_row(R_TRAP, CSR_OP_WRITE, CSR_MEPC, rand_word(), rand_word() & ~32'h3, 7'h4B, 1'b0);
    add_read(CSR_MEPC);
    add_read(CSR_MCAUSE);
    add_read(CSR_MSTATUS);
    // MRET pops IE
    add_row(R_MRET, CSR_OP_READ, '0, '0, '0, '0, 1'b0);
    add_read(CSR_MSTATUS);
    add_row(R_TRAP, CSR_OP_READ, '0, '0, rand_word() & ~32'h3, 7'h02, 1'b0);
    add_read(CSR_MCAUSE);
    // MRET with mpie clear
    add_wb(CSR_OP_WRITE, CSR_MSTATUS, 32'h0000_0000);
    add_row(R_MRET, CSR_OP_READ, '0, '0, '0, '0, 1'b0);
    add_read(CSR_MSTATUS);
    // Counters
    add_wb(CSR_OP_CLEAR, CSR_MCOUNTINHIBIT, 32'h1);
    add_read(CSR_MCYCLE);
    add_row(R_IDLE, CSR_OP_READ, '0, '0, 7, '0, 1'b0);
    add_read(CSR_MCYCLE);
    add_read(CSR_MCOUNTINHIBIT);
    add_wb(CSR_OP_CLEAR, CSR_MCOUNTINHIBIT, 32'h4);
    add_row(R_RETIRE, CSR_OP_READ, '0, '0, 5, '0, 1'b0);
    add_read(CSR_MINSTRET);
    add_read(CSR_MINSTRETH);
    add_wb(CSR_OP_WRITE, CSR_MCYCLEH, rand_word());
    add_read(CSR_MCYCLEH);
    add_read(CSR_MCYCLE);
    add_wb(CSR_OP_SET, CSR_MCOUNTINHIBIT, 32'h5);
    add_read(CSR_MCYCLE);
    add_row(R_IDLE, CSR_OP_READ, '0, '0, 4, '0, 1'b0);
    add_read(CSR_MCYCLE);
    // mtvec boot load and software write
    add_row(R_INIT, CSR_OP_READ, '0, rand_word(), '0, '0, 1'b0);
    add_read(CSR_MTVEC);
    add_wb(CSR_OP_WRITE, CSR_MTVEC, rand_word());
    add_read(CSR_MTVEC);
  endtask

  function automatic int unsigned row_cycles(input row_t r);
    return (r.kind == R_IDLE || r.kind == R_RETIRE) ? r.aux : 1;
  endfunction

  task automatic apply_row(input row_t r);
    rd_req     = '{valid: (r.kind == R_READ), op: r.op, addr: r.addr};
    mtvec_init = (r.kind == R_INIT);
    boot_addr  = r.data;
    retire     = (r.kind == R_RETIRE);
    if (r.kind inside {R_WB, R_KILL, R_TRAP})   // Old value as read in EX
      wb_req = '{valid: 1'b1, kill: (r.kind == R_KILL), op: r.op, addr: r.addr,
                 operand: r.data, old_value: model_read(r.addr)};
    trap = '{save_cause: (r.kind == R_TRAP), restore_mret: (r.kind == R_MRET),
             cause: r.cause, pc: r.aux};
    #2;
    if (r.kind == R_READ)
      check_data($sformatf("rd_data_o[%03h]", r.addr), rd_data, model_read(r.addr));
    if (r.kind inside {R_READ, R_NOREAD})
      check_flag("illegal_o", illegal, r.exp_ill);
    check_mtvec(m_tvec);
    check_irq_mepc(m_st_mie, m_ie, m_epc);
    repeat (row_cycles(r)) begin
      @(posedge clk);
      model_update();
      @(negedge clk);
    end
    rd_req     = '0;
    wb_req     = '0;
    trap       = '0;
    mtvec_init = 1'b0;
    retire     = 1'b0;
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////
  initial begin
    longint cycles;
    rst_n      = 1'b0;
    rd_req     = '0;
    wb_req     = '0;
    trap       = '0;
    mtvec_init = 1'b0;
    boot_addr  = '0;
    retire     = 1'b0;
    hart_id    = 32'h0000_0003;
    rng        = 32'h7647_e498;
    mip        = rand_word();
    // Model reset state
    m_st_mie  = 1'b0;
    m_st_mpie = 1'b0;
    m_ie      = '0;
    m_scratch = '0;
    m_epc     = '0;
    m_cause   = '0;
    m_inh     = CNT_INHIBIT_RESET;
    m_tvec    = MTVEC_RESET_VAL;
    m_cycle   = '0;
    m_instret = '0;
    build_table();
    cycles = 0;
    foreach (rows[i]) cycles += row_cycles(rows[i]);
    timeout_ns = (cycles + 16 + 64) * 10 + 500;   // Arms watchdog
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    foreach (rows[i]) apply_row(rows[i]);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Watchdog
  initial begin
    wait (timeout_ns != 0);
    #(timeout_ns);
    report_failure("Timeout, the test sequence did not complete in time");
  end

endmodule
